// ==== hw/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Cycles a request spends in its channel pipeline
`define MEM_DELAY_CYCLES 4

// Width of an address word in bits
`define WORD_SIZE 32

// Width of one cache line in bits
`define CACHE_LINE_SIZE 128

// Byte offset bits inside a line that holds 16 bytes
`define OFFSET_SIZE 4

// Number of lines held by the array
`define MEM_LINES 64

// Line index bits needed to select one of MEM_LINES
`define INDEX_SIZE 6

`endif

// ==== hw/mem_pkg.sv ====
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

    // One address word as seen on the request ports
    typedef logic [`WORD_SIZE-1:0] word_t;

    // One full cache line
    typedef logic [`CACHE_LINE_SIZE-1:0] line_t;

    // Field view of an address word
    // High bits alias onto the same line
    typedef struct packed {
        logic [`WORD_SIZE-`INDEX_SIZE-`OFFSET_SIZE-1:0] high;
        logic [`INDEX_SIZE-1:0]                         index;
        logic [`OFFSET_SIZE-1:0]                        offset;
    } addr_fields_t;

    // The same word either carried whole or split into its fields
    typedef union packed {
        word_t        raw;
        addr_fields_t fields;
    } mem_addr_u;

endpackage

`default_nettype wire

// ==== hw/mem_req_delay.sv ====
`default_nettype none

module mem_req_delay #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  wire              clk,
    input  wire              i_rst_n,
    input  wire              i_valid,
    input  wire  [WIDTH-1:0] i_payload,
    output logic             o_valid,
    output logic [WIDTH-1:0] o_payload
);

    // Stage DEPTH-1 is the entry, stage 0 is the head
    logic             valid_q   [DEPTH];
    logic [WIDTH-1:0] payload_q [DEPTH];

    // Valid bits shift toward the head and clear on reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < DEPTH; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else begin
            for (int s = 0; s < DEPTH - 1; s++) begin
                valid_q[s] <= valid_q[s+1];
            end
            valid_q[DEPTH-1] <= i_valid;
        end
    end

    // Payload travels alongside its valid bit
    // A stage whose valid is low just carries stale data
    always_ff @(posedge clk) begin
        for (int s = 0; s < DEPTH - 1; s++) begin
            payload_q[s] <= payload_q[s+1];
        end
        payload_q[DEPTH-1] <= i_payload;
    end

    assign o_valid   = valid_q[0];
    assign o_payload = payload_q[0];

endmodule

`default_nettype wire

// ==== hw/mem_line_array.sv ====
`default_nettype none

`include "mem_consts.svh"

module mem_line_array (
    input  wire              clk,

    // Read port 0 serves the instruction channel
    input  wire mem_pkg::mem_addr_u i_rd0_addr,
    output mem_pkg::line_t          o_rd0_data,

    // Read port 1 serves the data channel
    input  wire mem_pkg::mem_addr_u i_rd1_addr,
    output mem_pkg::line_t          o_rd1_data,

    // The single write port takes whole lines only
    input  wire                     i_wen,
    input  wire mem_pkg::mem_addr_u i_w_addr,
    input  wire mem_pkg::line_t     i_w_data
);

    // Line storage starts out all zero and is never cleared afterwards
    mem_pkg::line_t lines_q [`MEM_LINES] = '{default: '0};

    logic [`INDEX_SIZE-1:0] rd0_index;
    logic [`INDEX_SIZE-1:0] rd1_index;
    logic [`INDEX_SIZE-1:0] w_index;

    // Only the index field picks the line
    // Offset and high bits fall away here
    assign rd0_index = i_rd0_addr.fields.index;
    assign rd1_index = i_rd1_addr.fields.index;
    assign w_index   = i_w_addr.fields.index;

    // Reads see the array as it stands before this edge's write
    assign o_rd0_data = lines_q[rd0_index];
    assign o_rd1_data = lines_q[rd1_index];

    always_ff @(posedge clk) begin
        if (i_wen) begin
            lines_q[w_index] <= i_w_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/main_memory.sv ====
`default_nettype none

`include "mem_consts.svh"

module main_memory (
    input  wire                 clk,
    input  wire                 i_rst_n,

    // Instruction cache read request
    input  wire                 i_i_read,
    input  wire mem_pkg::word_t i_i_addr,

    // Instruction cache read response
    output logic                o_i_res,
    output mem_pkg::line_t      o_i_res_data,
    output mem_pkg::word_t      o_i_res_addr,

    // Data cache read request
    input  wire                 i_d_read,
    input  wire mem_pkg::word_t i_d_addr,

    // Data cache read response
    output logic                o_d_res,
    output mem_pkg::line_t      o_d_res_data,
    output mem_pkg::word_t      o_d_res_addr,

    // Data cache line write
    input  wire                 i_d_wen,
    input  wire mem_pkg::word_t i_d_w_addr,
    input  wire mem_pkg::line_t i_d_w_data
);

    localparam int ADDR_W = `WORD_SIZE;
    localparam int LINE_W = `CACHE_LINE_SIZE;

    // A write carries its address above its line data
    localparam int WR_W = ADDR_W + LINE_W;

    // Heads of the instruction read pipeline
    logic           ird_head_valid;
    mem_pkg::word_t ird_head_addr;

    // Heads of the data read pipeline
    logic           drd_head_valid;
    mem_pkg::word_t drd_head_addr;

    // Write pipeline entry and head
    logic [WR_W-1:0] wr_in_payload;
    logic [WR_W-1:0] wr_head_payload;
    logic            wr_head_valid;
    mem_pkg::word_t  wr_head_addr;
    mem_pkg::line_t  wr_head_data;

    // Union views handed to the array
    mem_pkg::mem_addr_u ird_addr_u;
    mem_pkg::mem_addr_u drd_addr_u;
    mem_pkg::mem_addr_u wr_addr_u;

    // Read lines coming back from the array
    mem_pkg::line_t ird_line;
    mem_pkg::line_t drd_line;

    mem_req_delay #(
        .DEPTH     (`MEM_DELAY_CYCLES),
        .WIDTH     (ADDR_W)
    ) ird_dly (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_i_read),
        .i_payload (i_i_addr),
        .o_valid   (ird_head_valid),
        .o_payload (ird_head_addr)
    );

    mem_req_delay #(
        .DEPTH     (`MEM_DELAY_CYCLES),
        .WIDTH     (ADDR_W)
    ) drd_dly (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_d_read),
        .i_payload (i_d_addr),
        .o_valid   (drd_head_valid),
        .o_payload (drd_head_addr)
    );

    assign wr_in_payload = {i_d_w_addr, i_d_w_data};

    // The write leaves the head stage on the same edge it lands in the array
    mem_req_delay #(
        .DEPTH     (`MEM_DELAY_CYCLES),
        .WIDTH     (WR_W)
    ) wr_dly (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_d_wen),
        .i_payload (wr_in_payload),
        .o_valid   (wr_head_valid),
        .o_payload (wr_head_payload)
    );

    assign {wr_head_addr, wr_head_data} = wr_head_payload;

    assign ird_addr_u.raw = ird_head_addr;
    assign drd_addr_u.raw = drd_head_addr;
    assign wr_addr_u.raw  = wr_head_addr;

    mem_line_array lines_i (
        .clk        (clk),
        .i_rd0_addr (ird_addr_u),
        .o_rd0_data (ird_line),
        .i_rd1_addr (drd_addr_u),
        .o_rd1_data (drd_line),
        .i_wen      (wr_head_valid),
        .i_w_addr   (wr_addr_u),
        .i_w_data   (wr_head_data)
    );

    // Responses come straight off the pipeline heads
    // The echoed address keeps its offset and high bits
    assign o_i_res      = ird_head_valid;
    assign o_i_res_addr = ird_head_addr;
    assign o_i_res_data = ird_line;

    assign o_d_res      = drd_head_valid;
    assign o_d_res_addr = drd_head_addr;
    assign o_d_res_data = drd_line;

endmodule

`default_nettype wire

// ==== sim/main_memory_sva.sv ====
`default_nettype none

`include "mem_consts.svh"

module main_memory_sva (
    input wire clk,
    input wire i_rst_n,
    input wire i_i_read,
    input wire i_d_read,
    input wire o_i_res,
    input wire o_d_res
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int D = `MEM_DELAY_CYCLES;

    // Reset level seen at the last D edges with the newest in bit 0
    logic [D-1:0] rst_hist = '0;
    logic         started  = 1'b0;

    always_ff @(posedge clk) begin
        rst_hist <= {rst_hist[D-2:0], i_rst_n};
        started  <= 1'b1;
    end

    // With reset high all the way, each strobe reappears D edges later
    i_res_timing: assert property (@(posedge clk) disable iff (!i_rst_n)
        &rst_hist |-> o_i_res == $past(i_i_read, D))
        else $error("o_i_res does not match i_i_read from %0d edges before", D);

    d_res_timing: assert property (@(posedge clk) disable iff (!i_rst_n)
        &rst_hist |-> o_d_res == $past(i_d_read, D))
        else $error("o_d_res does not match i_d_read from %0d edges before", D);

    // A reset edge empties both read pipelines
    res_low_after_reset: assert property (@(posedge clk)
        started && !rst_hist[0] |-> !o_i_res && !o_d_res)
        else $error("read response strobe high right after a reset edge");

endmodule

`default_nettype wire

// ==== sim/main_memory_tb.sv ====
`default_nettype none

`include "mem_consts.svh"

module main_memory_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES    = 64;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESP_EDGES   = `MEM_DELAY_CYCLES - 1;

    logic           clk;
    logic           i_rst_n;
    logic           i_i_read;
    mem_pkg::word_t i_i_addr;
    logic           o_i_res;
    mem_pkg::line_t o_i_res_data;
    mem_pkg::word_t o_i_res_addr;
    logic           i_d_read;
    mem_pkg::word_t i_d_addr;
    logic           o_d_res;
    mem_pkg::line_t o_d_res_data;
    mem_pkg::word_t o_d_res_addr;
    logic           i_d_wen;
    mem_pkg::word_t i_d_w_addr;
    mem_pkg::line_t i_d_w_data;

    // Stimulus table with one entry per cycle
    logic           st_i_read [MAX_LINES];
    mem_pkg::word_t st_i_addr [MAX_LINES];
    logic           st_d_read [MAX_LINES];
    mem_pkg::word_t st_d_addr [MAX_LINES];
    logic           st_wen    [MAX_LINES];
    mem_pkg::word_t st_w_addr [MAX_LINES];
    mem_pkg::line_t st_w_data [MAX_LINES];
    mem_pkg::line_t st_i_exp  [MAX_LINES];
    mem_pkg::line_t st_d_exp  [MAX_LINES];

    // Outstanding reads per port with the oldest at the front
    int             i_due    [$];
    mem_pkg::word_t i_addr_q [$];
    mem_pkg::line_t i_data_q [$];
    int             d_due    [$];
    mem_pkg::word_t d_addr_q [$];
    mem_pkg::line_t d_data_q [$];

    int n_lines;
    int edge_cnt;
    bit loaded;

    main_memory dut_i (.*);

    bind main_memory main_memory_sva sva_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_i_read (i_i_read),
        .i_d_read (i_d_read),
        .o_i_res  (o_i_res),
        .o_d_res  (o_d_res)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %0h exp %0h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic load_stimulus();
        int           fd;
        int           cnt;
        string        text;
        logic [127:0] f [9];
        fd = $fopen("sim/main_memory_stimulus.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file could not be opened");
            $display("Something failed");
            $fatal(1);
        end
        n_lines = 0;
        while ($fgets(text, fd) != 0) begin
            // Comment and blank lines stand for no cycle
            if (text.len() < 9 || text[0] == "#") begin
                continue;
            end
            cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (cnt != 9 || n_lines == MAX_LINES) begin
                $display("Stimulus line %0d is malformed or does not fit the table", n_lines);
                $display("Something failed");
                $fatal(1);
            end
            st_i_read[n_lines] = f[0][0];
            st_i_addr[n_lines] = f[1][31:0];
            st_d_read[n_lines] = f[2][0];
            st_d_addr[n_lines] = f[3][31:0];
            st_wen[n_lines]    = f[4][0];
            st_w_addr[n_lines] = f[5][31:0];
            st_w_data[n_lines] = f[6];
            st_i_exp[n_lines]  = f[7];
            st_d_exp[n_lines]  = f[8];
            n_lines++;
        end
        $fclose(fd);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        edge_cnt++;
        #(DRIVE_DELAY);
    endtask

    // Inputs set now are sampled at the next edge
    task automatic drive_line(input int n);
        int due;
        due        = edge_cnt + 1 + RESP_EDGES;
        i_i_read   = st_i_read[n];
        i_i_addr   = st_i_addr[n];
        i_d_read   = st_d_read[n];
        i_d_addr   = st_d_addr[n];
        i_d_wen    = st_wen[n];
        i_d_w_addr = st_w_addr[n];
        i_d_w_data = st_w_data[n];
        if (st_i_read[n]) begin
            i_due.push_back(due);
            i_addr_q.push_back(st_i_addr[n]);
            i_data_q.push_back(st_i_exp[n]);
        end
        if (st_d_read[n]) begin
            d_due.push_back(due);
            d_addr_q.push_back(st_d_addr[n]);
            d_data_q.push_back(st_d_exp[n]);
        end
    endtask

    task automatic check_responses();
        logic exp_i;
        logic exp_d;
        exp_i = i_due.size() != 0 && i_due[0] == edge_cnt;
        exp_d = d_due.size() != 0 && d_due[0] == edge_cnt;
        check_eq("o_i_res", 128'(o_i_res), 128'(exp_i));
        check_eq("o_d_res", 128'(o_d_res), 128'(exp_d));
        if (exp_i) begin
            check_eq("o_i_res_addr", 128'(o_i_res_addr), 128'(i_addr_q[0]));
            check_eq("o_i_res_data", o_i_res_data, i_data_q[0]);
            void'(i_due.pop_front());
            void'(i_addr_q.pop_front());
            void'(i_data_q.pop_front());
        end
        if (exp_d) begin
            check_eq("o_d_res_addr", 128'(o_d_res_addr), 128'(d_addr_q[0]));
            check_eq("o_d_res_data", o_d_res_data, d_data_q[0]);
            void'(d_due.pop_front());
            void'(d_addr_q.pop_front());
            void'(d_data_q.pop_front());
        end
    endtask

    initial begin : timeout_watch
        int cycles;
        int limit;
        cycles = 0;
        wait (loaded);
        limit = n_lines + RESET_CYCLES + `MEM_DELAY_CYCLES + 20;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout, the run did not finish within %0d cycles", limit);
                $display("Something failed");
                $fatal(1);
            end
        end
    end

    initial begin : main_flow
        int n;
        i_rst_n    = 1'b0;
        i_i_read   = 1'b0;
        i_i_addr   = '0;
        i_d_read   = 1'b0;
        i_d_addr   = '0;
        i_d_wen    = 1'b0;
        i_d_w_addr = '0;
        i_d_w_data = '0;
        edge_cnt   = 0;
        load_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) begin
            step_cycle();
            check_eq("o_i_res", 128'(o_i_res), 128'(0));
            check_eq("o_d_res", 128'(o_d_res), 128'(0));
        end
        i_rst_n = 1'b1;
        for (n = 0; n < n_lines; n++) begin
            step_cycle();
            check_responses();
            drive_line(n);
        end
        step_cycle();
        check_responses();
        i_i_read = 1'b0;
        i_d_read = 1'b0;
        i_d_wen  = 1'b0;
        // The last reads fall due within the read latency
        repeat (RESP_EDGES) begin
            step_cycle();
            check_responses();
        end
        // Nothing may come back once every read has been answered
        repeat (2) begin
            step_cycle();
            check_responses();
        end
        if (i_due.size() != 0 || d_due.size() != 0) begin
            $display("Some expected read responses never arrived");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/main_memory_stimulus.txt ====
# i_read i_addr d_read d_addr wen w_addr w_data i_exp d_exp, all hex, one line per cycle
# An expected line is only compared when its read strobe is 1
0 0 0 0 1 00000010 0123456789abcdeffedcba9876543210 0 0
0 0 0 0 1 00000020 deadbeef00112233445566778899aabb 0 0
0 0 0 0 1 00000050 cafef00d0000000100000002c0ffee00 0 0
0 0 0 0 1 000003f0 13579bdf2468ace0f0e1d2c3b4a59687 0 0
0 0 0 0 1 00000090 11111111222222223333333344444444 0 0
0 0 0 0 0 0 0 0 0
0 0 1 00000010 0 0 0 0 0123456789abcdeffedcba9876543210
0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0
1 00000020 1 00000050 0 0 0 deadbeef00112233445566778899aabb cafef00d0000000100000002c0ffee00
0 0 0 0 0 0 0 0 0
0 0 1 00000090 1 00000090 55555555666666667777777788888888 0 11111111222222223333333344444444
0 0 1 00000090 0 0 0 0 55555555666666667777777788888888
0 0 0 0 0 0 0 0 0
1 00000010 1 000003f0 0 0 0 0123456789abcdeffedcba9876543210 13579bdf2468ace0f0e1d2c3b4a59687
1 00000020 1 00000090 0 0 0 deadbeef00112233445566778899aabb 55555555666666667777777788888888
1 00000050 1 00000010 0 0 0 cafef00d0000000100000002c0ffee00 0123456789abcdeffedcba9876543210
1 000003f0 1 00000020 0 0 0 13579bdf2468ace0f0e1d2c3b4a59687 deadbeef00112233445566778899aabb
1 00000090 1 00000050 0 0 0 55555555666666667777777788888888 cafef00d0000000100000002c0ffee00
1 00000010 1 000003f0 0 0 0 0123456789abcdeffedcba9876543210 13579bdf2468ace0f0e1d2c3b4a59687
1 00000020 1 00000090 0 0 0 deadbeef00112233445566778899aabb 55555555666666667777777788888888
1 00000050 1 00000010 0 0 0 cafef00d0000000100000002c0ffee00 0123456789abcdeffedcba9876543210
0 0 0 0 0 0 0 0 0
1 0000001c 1 abcd0025 0 0 0 0123456789abcdeffedcba9876543210 deadbeef00112233445566778899aabb
1 fffffc5f 1 000043f8 0 0 0 cafef00d0000000100000002c0ffee00 13579bdf2468ace0f0e1d2c3b4a59687
1 8000001f 1 12345097 0 0 0 0123456789abcdeffedcba9876543210 55555555666666667777777788888888
0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0

// ==== tb.f ====
+incdir+hw
hw/mem_pkg.sv
hw/mem_req_delay.sv
hw/mem_line_array.sv
hw/main_memory.sv
sim/main_memory_sva.sv
sim/main_memory_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the main memory testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --assert --timescale 1ns/100ps \
    --top-module main_memory_tb -f tb.f -o Vmain_memory_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Build failed with status $build_status"
    exit 1
fi

./obj_dir/Vmain_memory_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "FAIL: the testbench reported an error"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "FAIL: the simulation exited with status $sim_status"
    exit 1
fi

if ! grep -q "Everything OK" "$LOG"; then
    echo "FAIL: the simulation ended without reaching its end of test"
    exit 1
fi

echo "PASS"
exit 0
